// ==== logic/riscvPkg.sv ====
`default_nettype none

package riscvPkg;

    // widths that carry meaning
    typedef logic [31:0] dataWord;       // register or immediate value
    typedef logic [31:0] instrWord;      // raw instruction
    typedef logic [4:0]  regAddr;        // register index

    // opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'd19;    // addi
    localparam logic [6:0] OP_BRANCH = 7'd99;    // beq, bne
    localparam logic [6:0] OP_LOAD   = 7'd3;     // lw, lb
    localparam logic [6:0] OP_STORE  = 7'd35;    // sw, sb
    localparam logic [6:0] OP_JALR   = 7'd103;
    localparam logic [6:0] OP_JAL    = 7'd111;

    // immediate layouts, all sign-extended from instr[31]
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,    // zero
        IMM_I    = 3'd1,    // instr[31:20]
        IMM_S    = 3'd2,    // instr[31:25], instr[11:7]
        IMM_B    = 3'd3,    // branch offset, bit 0 clear
        IMM_J    = 3'd4     // jal offset, bit 0 clear
    } immType;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1      // compare for branches
    } aluOp;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,     // load data
        RES_PC4 = 2'd2      // link address for jumps
    } resultSel;

    // all-zero value means no strobe active
    typedef struct packed {
        logic     regWrite;     // write result to rd
        logic     aluSrc;       // second operand is the immediate
        logic     memWrite;     // store
        logic     memByte;      // byte-sized access
        logic     branch;       // conditional branch
        logic     branchNe;     // taken on not-equal
        logic     jump;         // unconditional jump
        aluOp     aluCtrl;
        resultSel resultSrc;
    } ctrlBundle;

    // write-back into the register file
    typedef struct packed {
        logic    en;
        regAddr  addr;
        dataWord data;
    } wbPort;

    // everything the decode stage hands to execute
    typedef struct packed {
        ctrlBundle ctrl;
        logic      illegal;     // opcode or funct3 not supported
        regAddr    rd;
        dataWord   rs1Data;
        dataWord   rs2Data;
        dataWord   immExt;
    } decodeOut;

endpackage

`default_nettype wire

// ==== logic/controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic [6:0]          opcode,
    input  logic [2:0]          funct3,
    output riscvPkg::ctrlBundle ctrl,
    output riscvPkg::immType    immSel,
    output logic                illegal
);

    // funct3 encodings used by the subset
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BYTE = 3'b000;    // lb, sb
    localparam logic [2:0] F3_WORD = 3'b010;    // lw, sw
    localparam logic [2:0] F3_JALR = 3'b000;

    always_comb begin
        ctrl    = '0;                       // everything off unless matched
        immSel  = riscvPkg::IMM_NONE;
        illegal = 1'b0;

        case (opcode)
            riscvPkg::OP_IMM: begin
                case (funct3)
                    F3_ADDI: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.aluSrc    = 1'b1;
                        ctrl.aluCtrl   = riscvPkg::ALU_ADD;
                        ctrl.resultSrc = riscvPkg::RES_ALU;
                        immSel         = riscvPkg::IMM_I;
                    end
                    default: illegal = 1'b1;    // other ALU-immediate ops
                endcase
            end

            riscvPkg::OP_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE: begin
                        ctrl.branch   = 1'b1;
                        ctrl.branchNe = (funct3 == F3_BNE);
                        ctrl.aluCtrl  = riscvPkg::ALU_SUB;    // zero flag decides
                        immSel        = riscvPkg::IMM_B;
                    end
                    default: illegal = 1'b1;
                endcase
            end

            riscvPkg::OP_LOAD: begin
                case (funct3)
                    F3_WORD, F3_BYTE: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.aluSrc    = 1'b1;     // base + offset
                        ctrl.memByte   = (funct3 == F3_BYTE);
                        ctrl.aluCtrl   = riscvPkg::ALU_ADD;
                        ctrl.resultSrc = riscvPkg::RES_MEM;
                        immSel         = riscvPkg::IMM_I;
                    end
                    default: illegal = 1'b1;    // lh, lbu, lhu not handled
                endcase
            end

            riscvPkg::OP_STORE: begin
                case (funct3)
                    F3_WORD, F3_BYTE: begin
                        ctrl.memWrite = 1'b1;
                        ctrl.aluSrc   = 1'b1;
                        ctrl.memByte  = (funct3 == F3_BYTE);
                        ctrl.aluCtrl  = riscvPkg::ALU_ADD;
                        immSel        = riscvPkg::IMM_S;
                    end
                    default: illegal = 1'b1;
                endcase
            end

            riscvPkg::OP_JALR: begin
                case (funct3)
                    F3_JALR: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.aluSrc    = 1'b1;     // target is rs1 + imm
                        ctrl.jump      = 1'b1;
                        ctrl.aluCtrl   = riscvPkg::ALU_ADD;
                        ctrl.resultSrc = riscvPkg::RES_PC4;
                        immSel         = riscvPkg::IMM_I;
                    end
                    default: illegal = 1'b1;
                endcase
            end

            riscvPkg::OP_JAL: begin             // no funct3 field in J-type
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = riscvPkg::RES_PC4;
                immSel         = riscvPkg::IMM_J;
            end

            default: illegal = 1'b1;            // opcode outside the subset
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/signExtend.sv ====
`timescale 1ns/10ps
`default_nettype none

module signExtend #(
    parameter int D_WIDTH = 32
) (
    input  riscvPkg::instrWord instr,
    input  riscvPkg::immType   immSel,
    output riscvPkg::dataWord  immExt
);

    // fill widths above the raw immediate fields
    localparam int FILL_12 = D_WIDTH - 12;     // I, S and B formats
    localparam int FILL_20 = D_WIDTH - 20;     // J format

    logic sign;

    assign sign = instr[31];                    // sign bit sits here in every format

    always_comb begin
        case (immSel)
            riscvPkg::IMM_I: begin
                immExt = {{FILL_12{sign}}, instr[31:20]};
            end

            riscvPkg::IMM_S: begin              // split across funct7 and rd fields
                immExt = {{FILL_12{sign}}, instr[31:25], instr[11:7]};
            end

            riscvPkg::IMM_B: begin
                // imm[12] comes from the fill, imm[11] from instr[7]
                immExt = {{FILL_12{sign}},
                          instr[7],
                          instr[30:25],
                          instr[11:8],
                          1'b0};
            end

            riscvPkg::IMM_J: begin
                // imm[20] in the fill, then 19:12, 11, 10:1
                immExt = {{FILL_20{sign}},
                          instr[19:12],
                          instr[20],
                          instr[30:21],
                          1'b0};
            end

            default: begin                      // IMM_NONE or unused codes
                immExt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile #(
    parameter int D_WIDTH   = 32,
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  riscvPkg::regAddr  rs1,
    input  riscvPkg::regAddr  rs2,
    input  riscvPkg::wbPort   wb,
    output riscvPkg::dataWord rs1Data,
    output riscvPkg::dataWord rs2Data
);

    logic [D_WIDTH-1:0] regs [REG_COUNT];

    // single write port that never writes x0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // async reads without write bypass
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage #(
    parameter int D_WIDTH   = 32,
    parameter int REG_COUNT = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  riscvPkg::instrWord instr,
    input  riscvPkg::wbPort    wb,
    output riscvPkg::decodeOut out
);

    // instruction fields
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    riscvPkg::regAddr rs1;
    riscvPkg::regAddr rs2;
    riscvPkg::regAddr rd;

    riscvPkg::ctrlBundle ctrl;
    riscvPkg::immType    immSel;
    logic                illegal;
    riscvPkg::dataWord   immExt;
    riscvPkg::dataWord   rs1Data;
    riscvPkg::dataWord   rs2Data;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    controlUnit u_controlUnit (
        .opcode  (opcode),
        .funct3  (funct3),
        .ctrl    (ctrl),
        .immSel  (immSel),
        .illegal (illegal)
    );

    signExtend #(
        .D_WIDTH (D_WIDTH)
    ) u_signExtend (
        .instr  (instr),
        .immSel (immSel),
        .immExt (immExt)
    );

    regFile #(
        .D_WIDTH   (D_WIDTH),
        .REG_COUNT (REG_COUNT)
    ) u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .wb      (wb),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // bundle for the execute stage
    always_comb begin
        out.ctrl    = ctrl;
        out.illegal = illegal;
        out.rd      = rd;
        out.rs1Data = rs1Data;
        out.rs2Data = rs2Data;
        out.immExt  = immExt;
    end

endmodule

`default_nettype wire

// ==== test/decodeChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeChecker #(
    parameter int NAME_BITS    = 192,
    parameter int SAMPLE_DELAY = 40         // ns after the falling edge
) (
    input  logic                 clk,
    input  logic                 valid,
    input  logic [NAME_BITS-1:0] name,
    input  riscvPkg::decodeOut   expOut,
    input  riscvPkg::decodeOut   dutOut,
    input  logic                 done,
    output int                   failCount,
    output int                   testCount
);

    int   fails   = 0;
    int   checked = 0;
    logic rowOk;

    assign failCount = fails;
    assign testCount = checked;

    task automatic compareField(input logic [8*8-1:0] label, input logic [31:0] expVal,
            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("mismatch %0s %0s: expected %h, actual %h", name, label, expVal, actVal);
            rowOk = 1'b0;
        end
    endtask

    task automatic checkRow();
        rowOk = 1'b1;
        compareField("ctrl",    32'(expOut.ctrl),    32'(dutOut.ctrl));
        compareField("illegal", 32'(expOut.illegal), 32'(dutOut.illegal));
        compareField("rd",      32'(expOut.rd),      32'(dutOut.rd));
        compareField("immExt",  expOut.immExt,       dutOut.immExt);
        compareField("rs1Data", expOut.rs1Data,      dutOut.rs1Data);
        compareField("rs2Data", expOut.rs2Data,      dutOut.rs2Data);
        checked++;
        if (rowOk) begin
            $display("ok       %0s", name);
        end else begin
            fails++;
            $display("failed   %0s", name);
        end
    endtask

    // sample late in the low phase before the write edge
    always @(negedge clk) begin
        #SAMPLE_DELAY;
        if (valid) begin
            checkRow();
        end
    end

    always @(posedge done) begin
        $display("checked %0d tests: %0d passed, %0d failed", checked, checked - fails, fails);
    end

endmodule

`default_nettype wire

// ==== test/decodeStageTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

    localparam int NAME_BITS = 8 * 24;
    localparam int CLK_HALF  = 50;             // 100 ns period

    typedef enum int {
        KIND_ADDI,
        KIND_BEQ,
        KIND_BNE,
        KIND_LW,
        KIND_LB,
        KIND_SW,
        KIND_SB,
        KIND_JALR,
        KIND_JAL
    } instrKind;

    typedef struct packed {
        logic               rst;                // reset held through this row
        riscvPkg::instrWord instr;
        riscvPkg::wbPort    wb;
        riscvPkg::decodeOut exp;
    } tableRow;

    logic               clk;
    logic               rst;
    riscvPkg::instrWord instr;
    riscvPkg::wbPort    wb;
    riscvPkg::decodeOut decOut;

    riscvPkg::decodeOut   expOut;
    logic [NAME_BITS-1:0] curName;
    logic                 checkValid;
    logic                 done;
    logic                 tableReady;
    int                   failCount;
    int                   testCount;
    int                   limitCycles;

    tableRow              rows[$];
    logic [NAME_BITS-1:0] names[$];
    riscvPkg::dataWord    shadow [32];         // expected register contents
    riscvPkg::dataWord    lcgState;

    decodeStage #(
        .D_WIDTH   (32),
        .REG_COUNT (32)
    ) u_decodeStage (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .wb    (wb),
        .out   (decOut)
    );

    decodeChecker #(
        .NAME_BITS (NAME_BITS)
    ) u_decodeChecker (
        .clk       (clk),
        .valid     (checkValid),
        .name      (curName),
        .expOut    (expOut),
        .dutOut    (decOut),
        .done      (done),
        .failCount (failCount),
        .testCount (testCount)
    );

    function automatic riscvPkg::dataWord lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // ISA encoding as the inverse of the decoder
    function automatic riscvPkg::instrWord encodeInstr(instrKind kind, int imm,
            riscvPkg::regAddr rd, riscvPkg::regAddr rs1, riscvPkg::regAddr rs2);
        logic [31:0]        v;
        riscvPkg::instrWord w;
        v = imm;
        case (kind)
            KIND_ADDI: w = {v[11:0], rs1, 3'b000, rd, riscvPkg::OP_IMM};
            KIND_BEQ:  w = {v[12], v[10:5], rs2, rs1, 3'b000, v[4:1], v[11], riscvPkg::OP_BRANCH};
            KIND_BNE:  w = {v[12], v[10:5], rs2, rs1, 3'b001, v[4:1], v[11], riscvPkg::OP_BRANCH};
            KIND_LW:   w = {v[11:0], rs1, 3'b010, rd, riscvPkg::OP_LOAD};
            KIND_LB:   w = {v[11:0], rs1, 3'b000, rd, riscvPkg::OP_LOAD};
            KIND_SW:   w = {v[11:5], rs2, rs1, 3'b010, v[4:0], riscvPkg::OP_STORE};
            KIND_SB:   w = {v[11:5], rs2, rs1, 3'b000, v[4:0], riscvPkg::OP_STORE};
            KIND_JALR: w = {v[11:0], rs1, 3'b000, rd, riscvPkg::OP_JALR};
            KIND_JAL:  w = {v[20], v[10:1], v[11], v[19:12], rd, riscvPkg::OP_JAL};
            default:   w = '0;
        endcase
        return w;
    endfunction

    function automatic riscvPkg::ctrlBundle expectedCtrl(instrKind kind);
        riscvPkg::ctrlBundle c;
        c = '0;                                 // add, alu result, no strobes
        case (kind)
            KIND_ADDI: begin
                c.regWrite = 1'b1;
                c.aluSrc   = 1'b1;
            end
            KIND_BEQ, KIND_BNE: begin
                c.branch   = 1'b1;
                c.branchNe = (kind == KIND_BNE);
                c.aluCtrl  = riscvPkg::ALU_SUB;
            end
            KIND_LW, KIND_LB: begin
                c.regWrite  = 1'b1;
                c.aluSrc    = 1'b1;
                c.memByte   = (kind == KIND_LB);
                c.resultSrc = riscvPkg::RES_MEM;
            end
            KIND_SW, KIND_SB: begin
                c.memWrite = 1'b1;
                c.aluSrc   = 1'b1;
                c.memByte  = (kind == KIND_SB);
            end
            KIND_JALR: begin
                c.regWrite  = 1'b1;
                c.aluSrc    = 1'b1;
                c.jump      = 1'b1;
                c.resultSrc = riscvPkg::RES_PC4;
            end
            default: begin                      // jal
                c.regWrite  = 1'b1;
                c.jump      = 1'b1;
                c.resultSrc = riscvPkg::RES_PC4;
            end
        endcase
        return c;
    endfunction

    task automatic clearShadow();
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
    endtask

    // reads see the shadow before this row's write lands
    task automatic pushRow(input logic [NAME_BITS-1:0] name, input riscvPkg::instrWord word,
            input riscvPkg::ctrlBundle ctrl, input logic illegal, input riscvPkg::dataWord imm,
            input logic wbEn, input riscvPkg::regAddr wbAddr, input logic rstRow);
        tableRow r;
        r.rst         = rstRow;
        r.instr       = word;
        r.exp.ctrl    = ctrl;
        r.exp.illegal = illegal;
        r.exp.rd      = word[11:7];
        r.exp.rs1Data = shadow[word[19:15]];
        r.exp.rs2Data = shadow[word[24:20]];
        r.exp.immExt  = imm;
        r.wb.en       = wbEn;
        r.wb.addr     = wbAddr;
        r.wb.data     = lcgNext();              // data present even with en low
        rows.push_back(r);
        names.push_back(name);
        if (rstRow) begin
            clearShadow();                      // reset wins over the write
        end else if (wbEn && wbAddr != 5'd0) begin
            shadow[wbAddr] = r.wb.data;
        end
    endtask

    task automatic addLegal(input logic [NAME_BITS-1:0] name, input instrKind kind,
            input int imm, input riscvPkg::regAddr rd, input riscvPkg::regAddr rs1,
            input riscvPkg::regAddr rs2, input logic wbEn, input riscvPkg::regAddr wbAddr);
        pushRow(name, encodeInstr(kind, imm, rd, rs1, rs2), expectedCtrl(kind), 1'b0,
                imm, wbEn, wbAddr, 1'b0);
    endtask

    // nonzero immediate field with bit 31 high must still decode to zero
    task automatic addIllegal(input logic [NAME_BITS-1:0] name, input logic [6:0] opcode,
            input logic [2:0] f3, input riscvPkg::regAddr rd, input riscvPkg::regAddr rs1,
            input logic wbEn, input riscvPkg::regAddr wbAddr);
        pushRow(name, {12'h8a5, rs1, f3, rd, opcode}, '0, 1'b1, '0, wbEn, wbAddr, 1'b0);
    endtask

    // mid-run reset that must also drop a pending write to x21
    task automatic insertReset(input logic [NAME_BITS-1:0] name);
        pushRow(name, encodeInstr(KIND_ADDI, 5, 1, 12, 0), expectedCtrl(KIND_ADDI), 1'b0, 5,
                1'b1, 21, 1'b1);
    endtask

    task automatic buildTable();
        riscvPkg::dataWord r;
        clearShadow();                          // state right after reset
        addLegal("rst_read_a",  KIND_ADDI,   31,  1,  5,  0, 1'b0,  0);
        addLegal("rst_read_b",  KIND_BEQ,     8,  0, 17, 30, 1'b0,  0);
        addLegal("wr_x5_same",  KIND_ADDI,    1,  3,  5,  0, 1'b1,  5);
        addLegal("rd_x5_next",  KIND_ADDI,   -1,  4,  5,  0, 1'b1,  6);
        addLegal("wr_x0",       KIND_SW,      4,  0,  6,  5, 1'b1,  0);
        addLegal("rd_x0",       KIND_SW,     -4,  0,  0,  6, 1'b1,  7);
        addLegal("wr_no_en",    KIND_BNE,    -8,  0,  6,  7, 1'b0,  9);
        addLegal("rd_x9",       KIND_BEQ,    16,  0,  9,  7, 1'b1, 31);
        addLegal("addi_pos",    KIND_ADDI, 2047, 10, 31,  0, 1'b0,  0);
        addLegal("addi_neg",    KIND_ADDI, -2048, 11, 7,  0, 1'b1, 12);
        addLegal("beq_pos",     KIND_BEQ,  4094,  0, 12,  5, 1'b0,  0);
        addLegal("beq_neg",     KIND_BEQ, -4096,  0, 31,  6, 1'b0,  0);
        addLegal("bne_pos",     KIND_BNE,     2,  0,  1,  2, 1'b0,  0);
        addLegal("bne_neg",     KIND_BNE,    -2,  0,  5,  6, 1'b1, 13);
        addLegal("lw_pos",      KIND_LW,    100, 14, 13,  0, 1'b0,  0);
        addLegal("lw_neg",      KIND_LW,   -100, 15,  5,  0, 1'b0,  0);
        addLegal("lb_pos",      KIND_LB,      7, 16,  6,  0, 1'b1, 20);
        addLegal("lb_neg",      KIND_LB,     -1, 17, 20,  0, 1'b0,  0);
        addLegal("sw_pos",      KIND_SW,   1234,  0, 20, 13, 1'b0,  0);
        addLegal("sw_neg",      KIND_SW,  -2048,  0,  7, 31, 1'b0,  0);
        addLegal("sb_pos",      KIND_SB,     33,  0,  6,  5, 1'b0,  0);
        addLegal("sb_neg",      KIND_SB,    -33,  0, 12, 20, 1'b0,  0);
        addLegal("jalr_pos",    KIND_JALR,   12,  1,  5,  0, 1'b0,  0);
        addLegal("jalr_neg",    KIND_JALR,  -12,  1, 13,  0, 1'b0,  0);
        addLegal("jal_pos",     KIND_JAL, 1048574, 1, 0,  0, 1'b0,  0);
        addLegal("jal_neg",     KIND_JAL, -1048576, 2, 0, 0, 1'b0,  0);
        addLegal("jal_bit11",   KIND_JAL,  2048,  3,  0,  0, 1'b0,  0);
        addIllegal("ill_lh",      7'd3,         3'd1,  8,  5, 1'b1, 21);
        addIllegal("ill_rtype",   7'b0110011,   3'd0,  9,  6, 1'b0,  0);
        addIllegal("ill_slli",    7'd19,        3'd1, 10, 13, 1'b0,  0);
        addIllegal("ill_blt",     7'd99,        3'd4, 11, 21, 1'b0,  0);
        addIllegal("ill_sh",      7'd35,        3'd1, 12, 20, 1'b0,  0);
        addIllegal("ill_jalr_f3", 7'd103,       3'd2, 13,  7, 1'b0,  0);
        addIllegal("ill_lui",     7'b0110111,   3'd0, 14, 31, 1'b0,  0);
        addIllegal("ill_opcode0", 7'd0,         3'd0, 15, 12, 1'b0,  0);
        for (int k = 0; k < 4; k++) begin
            r = lcgNext();
            addLegal("rand_lw", KIND_LW, {{20{r[11]}}, r[11:0]}, r[16:12], r[21:17], 0,
                     1'b1, r[26:22]);
        end
        addLegal("rd_x13_x20",  KIND_BEQ,    -6,  0, 13, 20, 1'b0,  0);
        addLegal("rd_x21_x12",  KIND_BNE,    10,  0, 21, 12, 1'b0,  0);
        insertReset("rst_mid");
        addLegal("rd_after_rst_a", KIND_BEQ,  -6,  0, 13, 20, 1'b0,  0);
        addLegal("rd_after_rst_b", KIND_SW,    8,  0, 21,  5, 1'b0,  0);
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        wait (tableReady);
        repeat (limitCycles) @(posedge clk);
        $display("timeout: the test sequence did not finish within %0d cycles", limitCycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        instr      = '0;
        wb         = '0;
        expOut     = '0;
        curName    = '0;
        checkValid = 1'b0;
        done       = 1'b0;
        tableReady = 1'b0;
        lcgState   = 32'h6475_216d;
        buildTable();
        limitCycles = rows.size() * 4 + 20;
        tableReady  = 1'b1;

        repeat (3) @(posedge clk);              // three reset edges
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            rst        = rows[i].rst;
            instr      = rows[i].instr;
            wb         = rows[i].wb;
            expOut     = rows[i].exp;
            curName    = names[i];
            checkValid = 1'b1;
            @(negedge clk);
        end
        checkValid = 1'b0;
        wb         = '0;
        @(negedge clk);

        done = 1'b1;                            // checker prints its counts
        #1;
        if (failCount == 0 && testCount == rows.size()) begin
            $display(">>> PASS");
        end else begin
            if (testCount != rows.size()) begin
                $display("only %0d of %0d tests were checked", testCount, rows.size());
            end
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decodeStage.f ====
logic/riscvPkg.sv
logic/controlUnit.sv
logic/signExtend.sv
logic/regFile.sv
logic/decodeStage.sv
test/decodeChecker.sv
test/decodeStageTb.sv

// ==== Makefile ====
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/10ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
TOP        := decodeStageTb
FILELIST   := decodeStage.f
OBJDIR     := obj_dir
SIM        := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# status comes from the search for the pass line
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx ">>> PASS"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
